// ==== Makefile ====
# Verilator build for the multiply unit

VERILATOR  ?= verilator
FILELIST   ?= mul_unit.f
TB_TOP     ?= tb_mul_unit
RTL_TOP    ?= mul_unit_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/mul_unit_cfg.svh ====
// ==============================
// Multiply unit configuration
// ==============================

`ifndef MUL_UNIT_CFG_SVH
`define MUL_UNIT_CFG_SVH

// Operand width in bits
// The Karatsuba split needs an even width, and 64 works as well as 128
`define MU_WIDTH 128

// Width of the command tag carried through to the result
`define MU_TAG_W 4

// Result queue depth
// The sender starts with this many command credits
`define MU_QUEUE_DEPTH 4

// Credits held toward the consumer after reset
`define MU_RES_CREDITS 2

`endif

// ==== mul_unit.f ====
+incdir+include
rtl/mul_unit_pkg.sv
rtl/karatsuba_mul128.sv
rtl/mul_cmd_decode.sv
rtl/mul_execute.sv
rtl/mul_result.sv
rtl/mul_unit_top.sv
tb/tb_clk_gen.sv
tb/tb_mul_unit.sv

// ==== rtl/karatsuba_mul128.sv ====
// ==============================
// Karatsuba multiplier
// ==============================

`timescale 1ns/1ps

`include "mul_unit_cfg.svh"

module karatsuba_mul128 (
  input  logic [`MU_WIDTH-1:0]   a,
  input  logic [`MU_WIDTH-1:0]   b,
  output logic [2*`MU_WIDTH-1:0] prod
);

  localparam int W = `MU_WIDTH;
  localparam int H = W / 2;

  // Operand halves
  logic [H-1:0] a_hi;
  logic [H-1:0] a_lo;
  logic [H-1:0] b_hi;
  logic [H-1:0] b_lo;

  // Cross differences with a sign bit on top
  logic [H:0]   diff_a;
  logic [H:0]   diff_b;
  logic [H:0]   neg_a;
  logic [H:0]   neg_b;
  logic [H-1:0] mag_a;
  logic [H-1:0] mag_b;
  logic         cross_neg;

  // The three half-width products
  logic [W-1:0] z_hi;
  logic [W-1:0] z_lo;
  logic [W-1:0] z_cross;

  // Middle term with one extra bit for the carry
  logic [W:0]   cross_term;
  logic [W:0]   z_mid;

  always_comb begin
    a_hi = a[W-1:H];
    a_lo = a[H-1:0];
    b_hi = b[W-1:H];
    b_lo = b[H-1:0];

    // Differences taken as (a_lo - a_hi) and (b_hi - b_lo)
    // so their product adds to z_hi + z_lo to give the middle term
    diff_a = {1'b0, a_lo} - {1'b0, a_hi};
    diff_b = {1'b0, b_hi} - {1'b0, b_lo};

    // Magnitudes always fit in H bits
    neg_a = ~diff_a + 1'b1;
    neg_b = ~diff_b + 1'b1;
    mag_a = diff_a[H] ? neg_a[H-1:0] : diff_a[H-1:0];
    mag_b = diff_b[H] ? neg_b[H-1:0] : diff_b[H-1:0];
    cross_neg = diff_a[H] ^ diff_b[H];

    z_hi    = a_hi * b_hi;
    z_lo    = a_lo * b_lo;
    z_cross = mag_a * mag_b;

    // Restore the sign of the cross product
    cross_term = cross_neg ? (~{1'b0, z_cross} + 1'b1) : {1'b0, z_cross};

    // The true middle term a_hi*b_lo + a_lo*b_hi is below 2^(W+1)
    // so arithmetic modulo 2^(W+1) is exact
    z_mid = {1'b0, z_hi} + {1'b0, z_lo} + cross_term;

    // Outer products side by side plus the middle term shifted up by H
    prod = {z_hi, z_lo} + {{(H-1){1'b0}}, z_mid, {H{1'b0}}};
  end

endmodule

// ==== rtl/mul_cmd_decode.sv ====
// ==============================
// Command decode stage
// ==============================

`timescale 1ns/1ps

module mul_cmd_decode (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_valid,
  input  mul_unit_pkg::mul_cmd_t  cmd,
  output logic                    dec_valid,
  output mul_unit_pkg::mul_dec_t  dec
);

  import mul_unit_pkg::*;

  mul_dec_t dec_next;

  // Opcode classification
  // Only the high-half opcodes care about operand signs
  always_comb begin
    dec_next.tag       = cmd.tag;
    dec_next.a         = cmd.a;
    dec_next.b         = cmd.b;
    dec_next.a_signed  = 1'b0;
    dec_next.b_signed  = 1'b0;
    dec_next.take_high = 1'b1;
    unique case (cmd.op)
      // The low half is the same for every signedness
      MUL_LO: dec_next.take_high = 1'b0;
      MULHU:  dec_next.take_high = 1'b1;
      MULH: begin
        dec_next.a_signed = 1'b1;
        dec_next.b_signed = 1'b1;
      end
      MULHSU: dec_next.a_signed = 1'b1;
    endcase
  end

  // Valid follows the sampled command by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= cmd_valid;
    end
  end

  // Payload only loads with a command
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      dec <= dec_next;
    end
  end

endmodule

// ==== rtl/mul_execute.sv ====
// ==============================
// Two-stage execute
// ==============================

`timescale 1ns/1ps

`include "mul_unit_cfg.svh"

module mul_execute (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    dec_valid,
  input  mul_unit_pkg::mul_dec_t  dec,
  output logic                    ex_valid,
  output mul_unit_pkg::mul_res_t  ex_res
);

  import mul_unit_pkg::*;

  localparam int W = `MU_WIDTH;

  logic [2*W-1:0] prod;
  mul_ex_t        s1;
  logic           s1_valid;
  logic [W-1:0]   corr_a;
  logic [W-1:0]   corr_b;
  logic [W-1:0]   high_fixed;

  // Unsigned full product of the decoded operands
  karatsuba_mul128 u_karatsuba (
    .a    (dec.a),
    .b    (dec.b),
    .prod (prod)
  );

  // ==============================
  // Stage one
  // ==============================
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      s1.tag       <= dec.tag;
      s1.a         <= dec.a;
      s1.b         <= dec.b;
      s1.a_signed  <= dec.a_signed;
      s1.b_signed  <= dec.b_signed;
      s1.take_high <= dec.take_high;
      s1.prod      <= prod;
    end
  end

  // ==============================
  // Stage two
  // ==============================

  // A negative signed operand reads as x + 2^W when unsigned
  // so the extra 2^W times the other operand comes off the high half
  always_comb begin
    corr_a     = (s1.a_signed && s1.a[W-1]) ? s1.b : '0;
    corr_b     = (s1.b_signed && s1.b[W-1]) ? s1.a : '0;
    high_fixed = s1.prod[2*W-1:W] - corr_a - corr_b;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      ex_res.tag   <= s1.tag;
      ex_res.value <= s1.take_high ? high_fixed : s1.prod[W-1:0];
    end
  end

  // Valid shift chain with at most two commands in flight
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      ex_valid <= 1'b0;
    end else begin
      s1_valid <= dec_valid;
      ex_valid <= s1_valid;
    end
  end

endmodule

// ==== rtl/mul_result.sv ====
// ==============================
// Result queue and credits
// ==============================

`timescale 1ns/1ps

`include "mul_unit_cfg.svh"

module mul_result (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    ex_valid,
  input  mul_unit_pkg::mul_res_t  ex_res,
  input  logic                    res_credit,
  output logic                    res_valid,
  output mul_unit_pkg::mul_res_t  res,
  output logic                    cmd_credit
);

  import mul_unit_pkg::*;

  localparam int DEPTH  = `MU_QUEUE_DEPTH;
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(`MU_RES_CREDITS + DEPTH + 1);

  mul_res_t          mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credit_cnt;
  logic              push;
  logic              pop;

  // A credit arriving this cycle may be spent at once
  assign push = ex_valid;
  assign pop  = (count != '0) && ((credit_cnt != '0) || res_credit);

  // ==============================
  // Queue storage
  // ==============================

  // Write port at the write pointer
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= ex_res;
    end
  end

  // The popped entry is registered onto the output with res_valid
  always_ff @(posedge clk) begin
    if (pop) begin
      res <= mem[rd_ptr];
    end
  end

  // ==============================
  // Pointers, count and credits
  // ==============================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_cnt <= CRED_W'(`MU_RES_CREDITS);
      res_valid  <= 1'b0;
      cmd_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count unchanged
      count      <= count + CNT_W'(push) - CNT_W'(pop);
      credit_cnt <= credit_cnt + CRED_W'(res_credit) - CRED_W'(pop);
      // Each freed slot goes back to the sender as one credit
      res_valid  <= pop;
      cmd_credit <= pop;
    end
  end

endmodule

// ==== rtl/mul_unit_pkg.sv ====
// ==============================
// Multiply unit types
// ==============================

package mul_unit_pkg;

  `include "mul_unit_cfg.svh"

  // Opcodes accepted on the command side
  typedef enum logic [1:0] {
    MUL_LO = 2'd0,
    MULHU  = 2'd1,
    MULH   = 2'd2,
    MULHSU = 2'd3
  } mul_op_e;

  // Command as issued by the sender
  typedef struct packed {
    mul_op_e              op;
    logic [`MU_TAG_W-1:0] tag;
    logic [`MU_WIDTH-1:0] a;
    logic [`MU_WIDTH-1:0] b;
  } mul_cmd_t;

  // Command after decode
  // The opcode is gone and only the sign and half controls remain
  typedef struct packed {
    logic [`MU_TAG_W-1:0] tag;
    logic [`MU_WIDTH-1:0] a;
    logic [`MU_WIDTH-1:0] b;
    logic                 a_signed;
    logic                 b_signed;
    logic                 take_high;
  } mul_dec_t;

  // First execute stage holding the raw unsigned product
  typedef struct packed {
    logic [`MU_TAG_W-1:0]   tag;
    logic [`MU_WIDTH-1:0]   a;
    logic [`MU_WIDTH-1:0]   b;
    logic                   a_signed;
    logic                   b_signed;
    logic                   take_high;
    logic [2*`MU_WIDTH-1:0] prod;
  } mul_ex_t;

  // Result entry as queued and delivered to the consumer
  typedef struct packed {
    logic [`MU_TAG_W-1:0] tag;
    logic [`MU_WIDTH-1:0] value;
  } mul_res_t;

endpackage

// ==== rtl/mul_unit_top.sv ====
// ==============================
// Multiply unit top
// ==============================

`timescale 1ns/1ps

module mul_unit_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_valid,
  input  mul_unit_pkg::mul_cmd_t  cmd,
  output logic                    cmd_credit,
  output logic                    res_valid,
  output mul_unit_pkg::mul_res_t  res,
  input  logic                    res_credit
);

  import mul_unit_pkg::*;

  // Decode to execute
  logic     dec_valid;
  mul_dec_t dec;

  // Execute to result queue
  logic     ex_valid;
  mul_res_t ex_res;

  // One cycle to classify the opcode
  mul_cmd_decode u_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  // Two cycles for product, correction and half select
  mul_execute u_execute (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .dec       (dec),
    .ex_valid  (ex_valid),
    .ex_res    (ex_res)
  );

  // Credits on both sides keep the queue from ever overflowing
  mul_result u_result (
    .clk        (clk),
    .arst_n     (arst_n),
    .ex_valid   (ex_valid),
    .ex_res     (ex_res),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .res        (res),
    .cmd_credit (cmd_credit)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
// ==============================
// Testbench clock
// ==============================

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_NS = 50
) (
  output logic clk
);

  // Free running clock with a 100 ns period by default
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_NS) clk = ~clk;
    end
  end

endmodule

// ==== tb/tb_mul_unit.sv ====
// ==============================
// Multiply unit testbench
// ==============================

`timescale 1ns/1ps

`include "mul_unit_cfg.svh"

module tb_mul_unit;

  import mul_unit_pkg::*;

  localparam int W          = `MU_WIDTH;
  localparam int H          = W / 2;
  localparam int N_CORNER   = 48;
  localparam int N_RANDOM   = 160;
  localparam int TOTAL_CMDS = N_CORNER + 1 + `MU_QUEUE_DEPTH + `MU_RES_CREDITS + N_RANDOM;
  localparam int TIMEOUT_CYCLES = TOTAL_CMDS * 12 + 200;

  logic     clk;
  logic     arst_n;
  logic     cmd_valid;
  mul_cmd_t cmd;
  logic     cmd_credit;
  logic     res_valid;
  mul_res_t res;
  logic     res_credit;

  // Scoreboard and credit bookkeeping
  mul_res_t             exp_q[$];
  mul_res_t             exp_head;
  int                   errors;
  int                   send_cred;
  int                   delivered;
  int                   granted;
  int                   cmd_credits;
  int                   pending;
  int                   cyc;
  int                   last_res_edge;
  int                   credit_pct;
  bit                   manual;
  bit                   manual_req;
  bit                   sent_any;
  logic [31:0]          stim_seed;
  logic [31:0]          cons_seed;
  logic [`MU_TAG_W-1:0] next_tag;

  tb_clk_gen u_clk (.clk(clk));

  mul_unit_top u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  // Linear congruential step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Special operand values where the last two skew the Karatsuba cross differences
  function automatic logic [W-1:0] corner_value(input int idx);
    case (idx)
      0: return '0;
      1: return '1;
      2: return {1'b1, {(W-1){1'b0}}};
      3: return {1'b0, {(W-1){1'b1}}};
      4: return {{H{1'b1}}, {H{1'b0}}};
      default: return {{H{1'b0}}, {H{1'b1}}};
    endcase
  endfunction

  // Expected result from sign or zero extension and a full width product
  function automatic mul_res_t model_result(input mul_op_e op, input logic [`MU_TAG_W-1:0] tag,
                                            input logic [W-1:0] a, input logic [W-1:0] b);
    logic [2*W-1:0] ea;
    logic [2*W-1:0] eb;
    logic [2*W-1:0] full;
    mul_res_t       r;
    ea = (op == MULH || op == MULHSU) ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
    eb = (op == MULH) ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
    full    = ea * eb;
    r.tag   = tag;
    r.value = (op == MUL_LO) ? full[W-1:0] : full[2*W-1:W];
    return r;
  endfunction

  task automatic random_operand(output logic [W-1:0] v);
    for (int i = 0; i < W; i += 32) begin
      stim_seed = lcg_next(stim_seed);
      v[i +: 32] = stim_seed;
    end
    // One in eight operands is a corner value
    stim_seed = lcg_next(stim_seed);
    if (stim_seed[31:29] == 3'd0) begin
      v = corner_value(int'(stim_seed[15:8]) % 6);
    end
  endtask

  // Waits for a send credit at a drive point and issues one command
  task automatic send_cmd(input mul_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
    while (send_cred == 0) begin
      @(posedge clk);
      #10;
    end
    cmd_valid = 1'b1;
    cmd.op    = op;
    cmd.tag   = next_tag;
    cmd.a     = a;
    cmd.b     = b;
    exp_q.push_back(model_result(op, next_tag, a, b));
    exp_head  = exp_q[0];
    next_tag  = next_tag + 1'b1;
    send_cred = send_cred - 1;
    sent_any  = 1'b1;
    @(posedge clk);
    #10;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (exp_q.size() > 0 || pending > 0);
    repeat (3) @(posedge clk);
    #10;
  endtask

  // One consumer credit in manual mode and then time for the beat to appear
  task automatic give_credit();
    @(posedge clk);
    manual_req = 1'b1;
    repeat (6) @(posedge clk);
    #10;
  endtask

  // ==============================
  // Bookkeeping on pre-edge values
  // ==============================
  always @(posedge clk) begin
    if (arst_n) begin
      cyc = cyc + 1;
      if (res_valid) begin
        delivered     = delivered + 1;
        pending       = pending + 1;
        last_res_edge = cyc - 1;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end else begin
          errors = errors + 1;
          $display("Result delivered at %0t with no command outstanding", $time);
        end
        if (exp_q.size() > 0) begin
          exp_head = exp_q[0];
        end
      end
      if (cmd_credit) begin
        cmd_credits = cmd_credits + 1;
        send_cred   = send_cred + 1;
      end
      if (res_credit) begin
        granted = granted + 1;
      end
    end
  end

  // Consumer returns credits for the results it has taken
  always @(posedge clk) begin
    #10;
    res_credit = 1'b0;
    cons_seed  = lcg_next(cons_seed);
    if (manual) begin
      res_credit = manual_req;
      manual_req = 1'b0;
    end else if (arst_n && pending > 0 && int'(cons_seed[31:24]) % 100 < credit_pct) begin
      res_credit = 1'b1;
      pending    = pending - 1;
    end
  end

  // ==============================
  // Checks at the falling edge
  // ==============================
  assert property (@(negedge clk) disable iff (!arst_n) !res_valid || res.value == exp_head.value)
    else begin
      errors++;
      $display("** Error at %0t: res.value expected %h actual %h", $time, exp_head.value,
               res.value);
    end

  assert property (@(negedge clk) disable iff (!arst_n) !res_valid || res.tag == exp_head.tag)
    else begin
      errors++;
      $display("** Error at %0t: res.tag expected %h actual %h", $time, exp_head.tag, res.tag);
    end

  // A beat needs an unspent consumer credit
  assert property (@(negedge clk) disable iff (!arst_n) !res_valid || granted > delivered)
    else begin
      errors++;
      $display("** Error at %0t: res_valid expected 0 actual 1", $time);
    end

  assert property (@(negedge clk) disable iff (!arst_n) cmd_credit == res_valid)
    else begin
      errors++;
      $display("** Error at %0t: cmd_credit expected %b actual %b", $time, res_valid,
               cmd_credit);
    end

  // Nothing comes out before the first command
  assert property (@(negedge clk) disable iff (!arst_n) sent_any || (!res_valid && !cmd_credit))
    else begin
      errors++;
      $display("** Error at %0t: res_valid/cmd_credit expected 0 actual %b/%b", $time,
               res_valid, cmd_credit);
    end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * 100);
    $display("Timeout after %0d cycles, the DUT stopped returning results", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    logic [W-1:0] a;
    logic [W-1:0] b;
    int           s_edge;
    int           d0;
    int           c0;
    arst_n      = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    res_credit  = 1'b0;
    exp_head    = '0;
    errors      = 0;
    send_cred   = `MU_QUEUE_DEPTH;
    delivered   = 0;
    granted     = `MU_RES_CREDITS;
    cmd_credits = 0;
    pending     = 0;
    cyc         = 0;
    last_res_edge = 0;
    credit_pct  = 100;
    manual      = 1'b0;
    manual_req  = 1'b0;
    sent_any    = 1'b0;
    stim_seed   = 32'h2d76768d;
    cons_seed   = 32'h2d76768d ^ 32'hffff0000;
    next_tag    = '0;
    repeat (8) @(posedge clk);
    #10;
    arst_n = 1'b1;

    // Idle after reset
    repeat (10) @(posedge clk);
    #10;

    // Corner operands under every opcode
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < 6; i++) begin
        send_cmd(mul_op_e'(op), corner_value(i), corner_value(5 - i));
        send_cmd(mul_op_e'(op), corner_value(i), corner_value(i));
      end
    end
    wait_idle();

    // Isolated command latency
    s_edge = cyc + 1;
    send_cmd(MULH, corner_value(4), corner_value(2));
    wait_idle();
    assert (last_res_edge - s_edge == 4)
      else begin
        errors++;
        $display("** Error at %0t: latency expected 4 actual %0d", $time,
                 last_res_edge - s_edge);
      end

    // Consumer withholds credits
    manual = 1'b1;
    d0 = delivered;
    c0 = cmd_credits;
    for (int i = 0; i < `MU_QUEUE_DEPTH + `MU_RES_CREDITS; i++) begin
      random_operand(a);
      random_operand(b);
      send_cmd(mul_op_e'(i % 4), a, b);
    end
    repeat (20) @(posedge clk);
    #10;
    assert (delivered - d0 == `MU_RES_CREDITS)
      else begin
        errors++;
        $display("** Error at %0t: res_valid count expected %0d actual %0d", $time,
                 `MU_RES_CREDITS, delivered - d0);
      end
    assert (cmd_credits - c0 == `MU_RES_CREDITS)
      else begin
        errors++;
        $display("** Error at %0t: cmd_credit count expected %0d actual %0d", $time,
                 `MU_RES_CREDITS, cmd_credits - c0);
      end
    for (int k = 0; k < `MU_QUEUE_DEPTH; k++) begin
      give_credit();
      assert (delivered - d0 == `MU_RES_CREDITS + k + 1)
        else begin
          errors++;
          $display("** Error at %0t: delivered expected %0d actual %0d", $time,
                   `MU_RES_CREDITS + k + 1, delivered - d0);
        end
    end
    @(negedge clk);
    pending    = `MU_RES_CREDITS - (granted - delivered);
    manual     = 1'b0;
    credit_pct = 45;
    @(posedge clk);
    #10;

    // Long random run with random credit return
    for (int i = 0; i < N_RANDOM; i++) begin
      random_operand(a);
      random_operand(b);
      stim_seed = lcg_next(stim_seed);
      send_cmd(mul_op_e'(stim_seed[17:16]), a, b);
    end
    wait_idle();
    assert (cmd_credits == delivered)
      else begin
        errors++;
        $display("** Error at %0t: cmd_credit count expected %0d actual %0d", $time,
                 delivered, cmd_credits);
      end

    $display("Summary: %0d results delivered, %0d errors", delivered, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
